// File: build.f
+incdir+verification
hw/hub_pkg.sv
hw/hub_fifo_if.sv
hw/hub_fifo.sv
hw/outbound_gather.sv
hw/inbound_dispatch.sv
hw/final_arbitration_unit.sv
verification/tb_final_arbitration_unit.sv

// File: hw/final_arbitration_unit.sv
`timescale 1ns/100ps

module final_arbitration_unit (
    input logic clk,
    input logic reset,

    // master channels toward the hub
    input logic [hub_pkg::MASTER_CHANNEL_COUNT*hub_pkg::HUB_WORD_WIDTH-1:0]
        master_fifo_out_data_vector,
    input logic [hub_pkg::MASTER_CHANNEL_COUNT-1:0] master_fifo_out_valid_vector,
    output logic [hub_pkg::MASTER_CHANNEL_COUNT-1:0] master_fifo_out_ready_vector,

    // master channels from the hub
    output logic [hub_pkg::MASTER_CHANNEL_COUNT*hub_pkg::HUB_WORD_WIDTH-1:0]
        master_fifo_in_data_vector,
    output logic [hub_pkg::MASTER_CHANNEL_COUNT-1:0] master_fifo_in_valid_vector,
    input logic [hub_pkg::MASTER_CHANNEL_COUNT-1:0] master_fifo_in_ready_vector,

    // stage controller
    input hub_pkg::hub_word_t sc_fifo_out_data,
    input logic sc_fifo_out_valid,
    output logic sc_fifo_out_ready,
    output hub_pkg::hub_word_t sc_fifo_in_data,
    output logic sc_fifo_in_valid,
    input logic sc_fifo_in_ready,

    // board link side
    output hub_pkg::hub_word_t final_fifo_out_data,
    output logic final_fifo_out_valid,
    input logic final_fifo_out_ready,
    input hub_pkg::hub_word_t final_fifo_in_data,
    input logic final_fifo_in_valid,
    output logic final_fifo_in_ready,

    output logic has_flying_messages
);
    import hub_pkg::*;

    hub_fifo_if out_fifo_bus ();
    hub_fifo_if in_fifo_bus ();

    // nine-entry source view, stage controller last
    hub_word_t source_data [SOURCE_COUNT];
    source_mask_t source_valid;
    source_mask_t source_ready;

    hub_word_t dispatch_data;
    source_mask_t dispatch_valid;
    source_mask_t dispatch_ready;

    // merge master lanes and stage controller into sources
    for (genvar ch = 0; ch < MASTER_CHANNEL_COUNT; ch++) begin : g_lane
        assign source_data[ch] = master_fifo_out_data_vector[ch*HUB_WORD_WIDTH +: HUB_WORD_WIDTH];
    end
    assign source_data[MASTER_CHANNEL_COUNT] = sc_fifo_out_data;
    assign source_valid = {sc_fifo_out_valid, master_fifo_out_valid_vector};
    assign master_fifo_out_ready_vector = source_ready[MASTER_CHANNEL_COUNT-1:0];
    assign sc_fifo_out_ready = source_ready[MASTER_CHANNEL_COUNT];

    // outbound fifo, link side is the reader
    hub_fifo out_fifo (
        .clk(clk),
        .reset(reset),
        .bus(out_fifo_bus)
    );

    outbound_gather gather (
        .source_data(source_data),
        .source_valid(source_valid),
        .source_ready(source_ready),
        .out_fifo(out_fifo_bus)
    );

    assign final_fifo_out_data = out_fifo_bus.pop_data;
    assign final_fifo_out_valid = !out_fifo_bus.empty;
    assign out_fifo_bus.pop = final_fifo_out_ready;

    // inbound fifo, link side is the writer
    hub_fifo in_fifo (
        .clk(clk),
        .reset(reset),
        .bus(in_fifo_bus)
    );

    assign in_fifo_bus.push = final_fifo_in_valid;
    assign in_fifo_bus.push_data = final_fifo_in_data;
    assign final_fifo_in_ready = !in_fifo_bus.full;

    inbound_dispatch dispatch (
        .in_fifo(in_fifo_bus),
        .channel_data(dispatch_data),
        .channel_valid(dispatch_valid),
        .channel_ready(dispatch_ready)
    );

    // head word broadcast, the valid picks the lane
    assign master_fifo_in_data_vector = {MASTER_CHANNEL_COUNT{dispatch_data}};
    assign sc_fifo_in_data = dispatch_data;
    assign master_fifo_in_valid_vector = dispatch_valid[MASTER_CHANNEL_COUNT-1:0];
    assign sc_fifo_in_valid = dispatch_valid[MASTER_CHANNEL_COUNT];
    assign dispatch_ready = {sc_fifo_in_ready, master_fifo_in_ready_vector};

    // any valid seen last cycle, both directions
    always_ff @(posedge clk) begin
        if (reset) begin
            has_flying_messages <= 1'b0;
        end else begin
            has_flying_messages <= (|source_valid) || (|dispatch_valid)
                || final_fifo_out_valid || final_fifo_in_valid;
        end
    end

endmodule

// File: hw/hub_fifo.sv
`timescale 1ns/100ps

module hub_fifo (
    input logic clk,
    input logic reset,
    hub_fifo_if.fifo_side bus
);
    import hub_pkg::*;

    // storage, no reset needed on payload
    hub_word_t mem [HUB_FIFO_DEPTH];

    // depth is a power of two so pointers wrap on their own
    logic [$clog2(HUB_FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(HUB_FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(HUB_FIFO_DEPTH+1)-1:0] count;

    logic do_push;
    logic do_pop;

    assign bus.full = (count == HUB_FIFO_DEPTH);
    assign bus.empty = (count == '0);

    // push while full dropped, pop while empty ignored
    assign do_push = bus.push && !bus.full;
    assign do_pop = bus.pop && !bus.empty;

    // first word fall through
    assign bus.pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= bus.push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the level
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/hub_fifo_if.sv
`timescale 1ns/100ps

interface hub_fifo_if;
    import hub_pkg::*;

    // push side
    logic push;
    hub_word_t push_data;
    logic full;

    // pop side, head word shown while not empty
    logic pop;
    hub_word_t pop_data;
    logic empty;

    modport fifo_side (
        input push, push_data, pop,
        output full, pop_data, empty
    );

    modport writer (
        output push, push_data,
        input full
    );

    modport reader (
        output pop,
        input pop_data, empty
    );

endinterface

// File: hw/hub_pkg.sv
package hub_pkg;

    // message word and channel counts
    localparam int HUB_WORD_WIDTH = 32;
    localparam int MASTER_CHANNEL_COUNT = 8;
    // stage controller sits at the last source index
    localparam int SOURCE_COUNT = MASTER_CHANNEL_COUNT + 1;
    localparam int SOURCE_INDEX_WIDTH = 4;

    // destination field, bits 27..20, fpga id above it untouched
    localparam int CHANNEL_ID_WIDTH = 8;
    localparam int DEST_FIELD_LSB = 20;

    // both hub fifos
    localparam int HUB_FIFO_DEPTH = 16;

    // election tree padded to a full binary tree
    localparam int ELECTION_LEAF_COUNT = 2 ** SOURCE_INDEX_WIDTH;
    localparam int ELECTION_NODE_COUNT = 2 * ELECTION_LEAF_COUNT - 1;

    typedef logic [HUB_WORD_WIDTH-1:0] hub_word_t;
    typedef logic [CHANNEL_ID_WIDTH-1:0] channel_id_t;
    typedef logic [SOURCE_COUNT-1:0] source_mask_t;
    typedef logic [SOURCE_INDEX_WIDTH-1:0] source_index_t;

    // all ones addresses the stage controller
    localparam channel_id_t SC_CHANNEL_ID = '1;

endpackage

// File: hw/inbound_dispatch.sv
`timescale 1ns/100ps

module inbound_dispatch (
    hub_fifo_if.reader in_fifo,
    output hub_pkg::hub_word_t channel_data,
    output hub_pkg::source_mask_t channel_valid,
    input hub_pkg::source_mask_t channel_ready
);
    import hub_pkg::*;

    channel_id_t dest;
    source_index_t dest_index;
    logic dest_hit;

    // destination field of the head word
    assign dest = in_fifo.pop_data[DEST_FIELD_LSB +: CHANNEL_ID_WIDTH];

    // word goes out unchanged, fpga id included
    assign channel_data = in_fifo.pop_data;

    // map destination to a source index
    always_comb begin
        dest_hit = 1'b1;
        dest_index = '0;
        if (dest < channel_id_t'(MASTER_CHANNEL_COUNT)) begin
            dest_index = source_index_t'(dest);
        end else if (dest == SC_CHANNEL_ID) begin
            dest_index = source_index_t'(MASTER_CHANNEL_COUNT);
        end else begin
            // 8..254 address nothing
            dest_hit = 1'b0;
        end
    end

    // one valid at most, only for a known destination
    always_comb begin
        channel_valid = '0;
        if (!in_fifo.empty && dest_hit) begin
            channel_valid[dest_index] = 1'b1;
        end
    end

    // addressed channel ready pops the head
    // unknown destination is popped at once and lost
    assign in_fifo.pop = !in_fifo.empty && (dest_hit ? channel_ready[dest_index] : 1'b1);

endmodule

// File: hw/outbound_gather.sv
`timescale 1ns/100ps

module outbound_gather (
    input hub_pkg::hub_word_t source_data [hub_pkg::SOURCE_COUNT],
    input hub_pkg::source_mask_t source_valid,
    output hub_pkg::source_mask_t source_ready,
    hub_fifo_if.writer out_fifo
);
    import hub_pkg::*;

    // heap layout, root at 0, children of n at 2n+1 and 2n+2
    // leaves start at ELECTION_LEAF_COUNT-1
    logic node_valid [ELECTION_NODE_COUNT];
    source_index_t node_index [ELECTION_NODE_COUNT];
    hub_word_t node_data [ELECTION_NODE_COUNT];

    // leaf layer, unused leaves never win
    for (genvar leaf = 0; leaf < ELECTION_LEAF_COUNT; leaf++) begin : g_leaf
        if (leaf < SOURCE_COUNT) begin : g_source
            assign node_valid[ELECTION_LEAF_COUNT-1+leaf] = source_valid[leaf];
            assign node_index[ELECTION_LEAF_COUNT-1+leaf] = source_index_t'(leaf);
            assign node_data[ELECTION_LEAF_COUNT-1+leaf] = source_data[leaf];
        end else begin : g_pad
            assign node_valid[ELECTION_LEAF_COUNT-1+leaf] = 1'b0;
            assign node_index[ELECTION_LEAF_COUNT-1+leaf] = source_index_t'(leaf);
            assign node_data[ELECTION_LEAF_COUNT-1+leaf] = '0;
        end
    end

    // inner nodes
    // left child carries the lower index, so it wins whenever valid
    for (genvar node = 0; node < ELECTION_LEAF_COUNT - 1; node++) begin : g_node
        assign node_valid[node] = node_valid[2*node+1] | node_valid[2*node+2];
        assign node_index[node] = node_valid[2*node+1] ? node_index[2*node+1]
                                                       : node_index[2*node+2];
        assign node_data[node] = node_valid[2*node+1] ? node_data[2*node+1]
                                                      : node_data[2*node+2];
    end

    // root drives the outbound push
    // fifo drops the push by itself when full
    assign out_fifo.push = node_valid[0];
    assign out_fifo.push_data = node_data[0];

    // only the winner is accepted, and only with room in the fifo
    always_comb begin
        source_ready = '0;
        if (node_valid[0] && !out_fifo.full) begin
            source_ready[node_index[0]] = 1'b1;
        end
    end

endmodule

// File: verification/arbitration_stim.txt
// count valid_mask base_word out_ready ch_ready in_valid in_word exp_winner exp_channel
// all hex, f in the two expected columns means none
1 181 11110000 0 1ff 1 a0000000 0 f
1 180 11110000 0 1ff 1 a0100000 7 0
1 100 11110000 1 1ff 0 00000000 8 1
3 000 00000000 1 1ff 0 00000000 f f
10 001 22220000 0 1ff 0 00000000 0 f
2 1ff 33330000 0 1ff 0 00000000 f f
1 1ff 33330000 1 1ff 0 00000000 f f
1 1fe 33330000 0 1ff 0 00000000 1 f
14 000 00000000 1 1ff 0 00000000 f f
1 000 00000000 0 1ff 1 a0200000 f f
1 000 00000000 0 1ff 1 a0300000 f 2
1 000 00000000 0 1ff 1 a0400000 f 3
1 000 00000000 0 1ff 1 a0500000 f 4
1 000 00000000 0 1ff 1 a0600000 f 5
1 000 00000000 0 1ff 1 a0700000 f 6
1 000 00000000 0 1ff 1 aff00000 f 7
1 000 00000000 0 1ff 1 a0200000 f 8
1 000 00000000 0 1fb 1 a6400000 f 2
2 000 00000000 0 1fb 1 b0500000 f 2
1 000 00000000 0 1ff 0 00000000 f 2
1 000 00000000 0 1ff 0 00000000 f f
2 000 00000000 0 1ff 0 00000000 f 5

// File: verification/hub_checks.svh
`ifndef HUB_CHECKS_SVH
`define HUB_CHECKS_SVH

// compare tasks, one per kind of hub result
// included inside the testbench module, after the package import

task automatic check_word(input string name, input hub_word_t got, input hub_word_t expected);
    if (got !== expected) begin
        $display("error %s got %h expected %h", name, got, expected);
        stop_with_failure();
    end
endtask

// ready and valid masks, stage controller in the top bit
task automatic check_mask(input string name, input source_mask_t got,
                          input source_mask_t expected);
    if (got !== expected) begin
        $display("error %s got %h expected %h", name, got, expected);
        stop_with_failure();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
        $display("error %s got %h expected %h", name, got, expected);
        stop_with_failure();
    end
endtask

`endif

// File: verification/tb_final_arbitration_unit.sv
`timescale 1ns/100ps

module tb_final_arbitration_unit;
    import hub_pkg::*;

    // nine hex columns per stim row
    // the first column is the repeat count
    localparam int ROW_COUNT = 22;
    localparam int ROW_FIELDS = 9;
    localparam int TIMEOUT_CYCLES = ROW_COUNT * 20 + 100;
    localparam logic [3:0] NONE = 4'hf;

    logic clk;
    logic reset;
    logic [MASTER_CHANNEL_COUNT*HUB_WORD_WIDTH-1:0] master_fifo_out_data_vector;
    logic [MASTER_CHANNEL_COUNT-1:0] master_fifo_out_valid_vector;
    logic [MASTER_CHANNEL_COUNT-1:0] master_fifo_out_ready_vector;
    logic [MASTER_CHANNEL_COUNT*HUB_WORD_WIDTH-1:0] master_fifo_in_data_vector;
    logic [MASTER_CHANNEL_COUNT-1:0] master_fifo_in_valid_vector;
    logic [MASTER_CHANNEL_COUNT-1:0] master_fifo_in_ready_vector;
    hub_word_t sc_fifo_out_data;
    logic sc_fifo_out_valid;
    logic sc_fifo_out_ready;
    hub_word_t sc_fifo_in_data;
    logic sc_fifo_in_valid;
    logic sc_fifo_in_ready;
    hub_word_t final_fifo_out_data;
    logic final_fifo_out_valid;
    logic final_fifo_out_ready;
    hub_word_t final_fifo_in_data;
    logic final_fifo_in_valid;
    logic final_fifo_in_ready;
    logic has_flying_messages;

    logic [31:0] stim_mem [ROW_COUNT*ROW_FIELDS];
    // reference model of both fifos and the flag
    hub_word_t out_q [$];
    hub_word_t in_q [$];
    logic flying_expected;
    int cycle_count;

    final_arbitration_unit dut0 (.*);

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1, "run stopped at first failure");
    endtask

    `include "hub_checks.svh"

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // hang guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, stimulus replay did not finish in time");
            stop_with_failure();
        end
    end

    // destinations 8..254 name no channel and get dropped
    function automatic logic dest_dropped(input hub_word_t word);
        channel_id_t dest;
        dest = word[DEST_FIELD_LSB +: CHANNEL_ID_WIDTH];
        return dest >= MASTER_CHANNEL_COUNT && dest != SC_CHANNEL_ID;
    endfunction

    function automatic hub_word_t lane_word(input logic [3:0] lane);
        if (lane == MASTER_CHANNEL_COUNT) return sc_fifo_in_data;
        return master_fifo_in_data_vector[lane*HUB_WORD_WIDTH +: HUB_WORD_WIDTH];
    endfunction

    // one clock of a stim row
    // drive after the edge, check at the falling edge and then advance the model
    task automatic run_cycle(input int at);
        source_mask_t exp_ready;
        source_mask_t exp_disp;
        source_mask_t ch_ready;
        hub_word_t base_word;
        hub_word_t discard;
        logic [3:0] exp_win;
        logic [3:0] disp;
        logic in_full;
        logic next_flying;
        base_word = stim_mem[at+2] & ~32'hf;
        ch_ready = source_mask_t'(stim_mem[at+4]);
        exp_win = stim_mem[at+7][3:0];
        disp = stim_mem[at+8][3:0];
        @(posedge clk);
        #1;
        // each source word carries its own index in the low nibble
        for (int i = 0; i < MASTER_CHANNEL_COUNT; i++) begin
            master_fifo_out_data_vector[i*HUB_WORD_WIDTH +: HUB_WORD_WIDTH] = base_word | i;
        end
        sc_fifo_out_data = base_word | MASTER_CHANNEL_COUNT;
        {sc_fifo_out_valid, master_fifo_out_valid_vector} = stim_mem[at+1][8:0];
        {sc_fifo_in_ready, master_fifo_in_ready_vector} = ch_ready;
        final_fifo_out_ready = stim_mem[at+3][0];
        final_fifo_in_valid = stim_mem[at+5][0];
        // payload bits below the destination field are random
        final_fifo_in_data = stim_mem[at+6] | ($urandom & 32'h000f_ffff);
        @(negedge clk);
        exp_ready = '0;
        exp_disp = '0;
        if (exp_win != NONE) exp_ready[exp_win] = 1'b1;
        if (disp != NONE) exp_disp[disp] = 1'b1;
        check_mask("source_ready", {sc_fifo_out_ready, master_fifo_out_ready_vector}, exp_ready);
        check_flag("final_fifo_out_valid", final_fifo_out_valid, out_q.size() != 0);
        if (out_q.size() != 0) check_word("final_fifo_out_data", final_fifo_out_data, out_q[0]);
        check_flag("final_fifo_in_ready", final_fifo_in_ready, in_q.size() < HUB_FIFO_DEPTH);
        check_mask("channel_in_valid", {sc_fifo_in_valid, master_fifo_in_valid_vector}, exp_disp);
        if (disp != NONE) check_word("channel_in_data", lane_word(disp), in_q[0]);
        check_flag("has_flying_messages", has_flying_messages, flying_expected);
        // model state for the coming edge
        next_flying = (|stim_mem[at+1][8:0]) || (|exp_disp) || (out_q.size() != 0)
            || final_fifo_in_valid;
        if (final_fifo_out_ready && out_q.size() != 0) discard = out_q.pop_front();
        if (exp_win != NONE) out_q.push_back(base_word | exp_win);
        in_full = in_q.size() == HUB_FIFO_DEPTH;
        if (disp != NONE) begin
            if (ch_ready[disp]) discard = in_q.pop_front();
        end else if (in_q.size() != 0 && dest_dropped(in_q[0])) begin
            discard = in_q.pop_front();
        end
        if (final_fifo_in_valid && !in_full) in_q.push_back(final_fifo_in_data);
        flying_expected = next_flying;
    endtask

    initial begin
        int seed_value;
        reset = 1'b1;
        master_fifo_out_data_vector = '0;
        master_fifo_out_valid_vector = '0;
        master_fifo_in_ready_vector = '0;
        sc_fifo_out_data = '0;
        sc_fifo_out_valid = 1'b0;
        sc_fifo_in_ready = 1'b0;
        final_fifo_out_ready = 1'b0;
        final_fifo_in_data = '0;
        final_fifo_in_valid = 1'b0;
        flying_expected = 1'b0;
        cycle_count = 0;
        seed_value = $urandom(32'h16fda8f3);
        $readmemh("verification/arbitration_stim.txt", stim_mem);
        if ($isunknown(stim_mem[0])) begin
            $display("stimulus file could not be read");
            stop_with_failure();
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        // state right after reset
        check_flag("final_fifo_out_valid", final_fifo_out_valid, 1'b0);
        check_mask("channel_in_valid", {sc_fifo_in_valid, master_fifo_in_valid_vector}, '0);
        check_flag("final_fifo_in_ready", final_fifo_in_ready, 1'b1);
        check_flag("has_flying_messages", has_flying_messages, 1'b0);
        for (int row = 0; row < ROW_COUNT; row++) begin
            for (int rep = 0; rep < stim_mem[row*ROW_FIELDS]; rep++) begin
                run_cycle(row * ROW_FIELDS);
            end
        end
        // the last row's pops and pushes land on the next edge
        @(negedge clk);
        check_flag("final_fifo_out_valid", final_fifo_out_valid, out_q.size() != 0);
        check_flag("final_fifo_in_ready", final_fifo_in_ready, in_q.size() < HUB_FIFO_DEPTH);
        check_flag("has_flying_messages", has_flying_messages, flying_expected);
        if (in_q.size() == 0) begin
            check_mask("channel_in_valid", {sc_fifo_in_valid, master_fifo_in_valid_vector}, '0);
        end
        if (out_q.size() != 0 || in_q.size() != 0) begin
            $display("words still expected in a fifo at the end of the run");
            stop_with_failure();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule
